/* csrFile.sv */
/*
 CSR file
 Four scratch registers with write, set and clear, returning the old value
*/
`timescale 1ns/100ps

module csrFile import memPipePkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    csrReq,
    input  csrNum   csrNumber,
    input  csrCode  csrOp,
    input  dataWord csrWriteData,
    output dataWord csrReadData
);

    dataWord csrRegs [4];

    // Old value, the update lands at the edge
    assign csrReadData = csrRegs[csrNumber];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 4; i++) begin
                csrRegs[i] <= '0;
            end
        end else if (csrReq) begin
            case (csrOp)
                csrWrite: csrRegs[csrNumber] <= csrWriteData;
                csrSet:   csrRegs[csrNumber] <= csrRegs[csrNumber] | csrWriteData;
                csrClear: csrRegs[csrNumber] <= csrRegs[csrNumber] & ~csrWriteData;
                default:  csrRegs[csrNumber] <= csrRegs[csrNumber];
            endcase
        end
    end

endmodule

/* dataRam.sv */
/*
 Data RAM
 Single-port word array with a registered read
*/
`timescale 1ns/100ps

module dataRam import memPipePkg::*; #(
    parameter int depthLog2 = 8
) (
    input  logic    clk,
    input  logic    ramEnable,
    input  logic    ramWrite,
    input  memAddr  ramAddr,
    input  dataWord ramWriteData,
    output dataWord ramReadData
);

    dataWord              mem [2**depthLog2];
    logic [depthLog2-1:0] wordIndex;

    // Byte address to word index
    assign wordIndex = ramAddr[depthLog2+1:2];

    always_ff @(posedge clk) begin
        if (ramEnable) begin
            if (ramWrite) begin
                mem[wordIndex] <= ramWriteData;
            end else begin
                ramReadData <= mem[wordIndex];
            end
        end
    end

endmodule

/* memArbiter.sv */
/*
 Data RAM port arbiter
 Loads from the stage always win, store buffer drains take idle cycles
*/
`timescale 1ns/100ps

module memArbiter import memPipePkg::*; (
    input  logic    loadReq,
    input  memAddr  loadAddr,
    input  logic    drainValid,
    input  memAddr  drainAddr,
    input  dataWord drainData,
    output logic    drainGrant,
    output logic    ramEnable,
    output logic    ramWrite,
    output memAddr  ramAddr,
    output dataWord ramWriteData
);

    always_comb begin
        // Drain only in a cycle with no load
        drainGrant   = drainValid && !loadReq;
        ramEnable    = loadReq || drainValid;
        ramWrite     = drainGrant;
        ramAddr      = loadReq ? loadAddr : drainAddr;
        ramWriteData = drainData;
    end

endmodule

/* memExecStage.sv */
/*
 Memory execution stage
 Registers one memory op, resolves operands, forms and checks the address,
 and sends the op to the RAM, the store buffer or the CSR file
*/
`timescale 1ns/100ps

module memExecStage import memPipePkg::*; #(
    parameter int unsigned addrLimit = 1024
) (
    input  logic      clk,
    input  logic      arstN,
    input  memOp      opIn,
    input  bypassWord bypassInA,
    input  bypassWord bypassInB,
    input  logic      stall,
    input  logic      clear,
    input  logic      recoveryActive,
    input  opTag      flushHead,
    input  opTag      flushTail,
    input  logic      sbFull,
    input  logic      sbConflict,
    input  logic      sbEmpty,
    input  dataWord   ramReadData,
    input  dataWord   csrReadData,
    output logic      loadReq,
    output memAddr    loadAddr,
    output logic      storeReq,
    output memAddr    storeAddr,
    output dataWord   storeData,
    output memAddr    probeAddr,
    output logic      csrReq,
    output csrNum     csrNumber,
    output csrCode    csrOp,
    output dataWord   csrWriteData,
    output memResult  result
);

    memOp     pipeOp;
    logic     pipeValid;

    logic     isLoad;
    logic     isStore;
    logic     isCsr;
    logic     isFence;
    dataWord  fuOpA;
    dataWord  fuOpB;
    logic     validA;
    logic     validB;
    logic     needA;
    logic     regValid;
    dataWord  fullAddr;
    memAddr   addr;
    logic     addrBad;
    logic     flush;
    logic     kill;
    logic     replay;
    logic     fault;
    logic     issue;
    dataWord  nextData;

    logic     resValid;
    logic     resReplay;
    logic     resFault;
    logic     resIsLoad;
    opTag     resTag;
    memOpType resType;
    memAddr   resAddr;
    dataWord  resData;

    // Pipeline register holds while stalled
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= opIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeOp <= opIn;
        end
    end

    always_comb begin
        isLoad  = pipeOp.opType == opLoad;
        isStore = pipeOp.opType == opStore;
        isCsr   = pipeOp.opType == opCsr;
        isFence = pipeOp.opType == opFence;

        // Operand select
        fuOpA  = pipeOp.bypassA ? bypassInA.data  : pipeOp.operandA;
        validA = pipeOp.bypassA ? bypassInA.valid : pipeOp.readyA;
        fuOpB  = pipeOp.bypassB ? bypassInB.data  : pipeOp.operandB;
        validB = pipeOp.bypassB ? bypassInB.valid : pipeOp.readyB;

        // Only stores read B, FENCE reads nothing
        needA    = isLoad || isStore || (isCsr && !pipeOp.csrImm);
        regValid = (!needA || validA) && (!isStore || validB);

        // Address generation and range check
        fullAddr = fuOpA + {{20{pipeOp.imm[11]}}, pipeOp.imm};
        addr     = memAddr'(fullAddr);
        addrBad  = (isLoad || isStore) &&
                   ((fullAddr >= addrLimit) || (fullAddr[1:0] != 2'b00));

        flush = recoveryActive && tagInRange(flushHead, flushTail, pipeOp.tag);
        kill  = !pipeValid || stall || clear || flush;

        // No forwarding from the store buffer, so a hit is replayed
        replay = !regValid ||
                 (isLoad && !addrBad && sbConflict) ||
                 (isStore && !addrBad && sbFull) ||
                 (isFence && !sbEmpty);
        fault  = regValid && addrBad;
        issue  = !kill && !replay && !fault;

        loadReq   = issue && isLoad;
        storeReq  = issue && isStore;
        csrReq    = issue && isCsr;
        loadAddr  = addr;
        storeAddr = addr;
        probeAddr = addr;
        storeData = fuOpB;

        csrNumber    = csrNum'(pipeOp.imm[11:10]);
        csrOp        = pipeOp.csrOp;
        csrWriteData = pipeOp.csrImm ? {22'b0, pipeOp.imm[9:0]} : fuOpA;

        // Old CSR value for CSR ops, store data otherwise
        nextData = isCsr ? csrReadData : fuOpB;
    end

    // Result register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resValid  <= 1'b0;
            resReplay <= 1'b0;
            resFault  <= 1'b0;
            resIsLoad <= 1'b0;
        end else begin
            resValid  <= !kill;
            resReplay <= replay;
            resFault  <= fault;
            resIsLoad <= isLoad;
        end
    end

    always_ff @(posedge clk) begin
        resTag  <= pipeOp.tag;
        resType <= pipeOp.opType;
        resAddr <= addr;
        resData <= nextData;
    end

    // RAM read data lines up with the result register
    always_comb begin
        result.valid  = resValid;
        result.tag    = resTag;
        result.opType = resType;
        result.replay = resReplay;
        result.fault  = resFault;
        result.addr   = resAddr;
        result.data   = resIsLoad ? ramReadData : resData;
    end

endmodule

/* memPipePkg.sv */
/*
 Shared types for the memory execution lane
 Widths, op codes, the op and result structs and the flush range check
*/
package memPipePkg;

    typedef logic [31:0] dataWord;
    typedef logic [15:0] memAddr;
    typedef logic [3:0]  opTag;
    typedef logic [1:0]  csrNum;

    typedef enum logic [1:0] {
        opLoad,
        opStore,
        opCsr,
        opFence
    } memOpType;

    typedef enum logic [1:0] {
        csrWrite,
        csrSet,
        csrClear
    } csrCode;

    // CSR ops take the register number from imm[11:10]
    // With csrImm set, imm[9:0] zero-extended is the write value
    typedef struct packed {
        logic     valid;
        memOpType opType;
        opTag     tag;
        dataWord  operandA;
        dataWord  operandB;
        logic     readyA;
        logic     readyB;
        logic     bypassA;
        logic     bypassB;
        logic     [11:0] imm;
        csrCode   csrOp;
        logic     csrImm;
    } memOp;

    typedef struct packed {
        logic     valid;
        opTag     tag;
        memOpType opType;
        logic     replay;
        logic     fault;
        memAddr   addr;
        dataWord  data;
    } memResult;

    typedef struct packed {
        dataWord data;
        logic    valid;
    } bypassWord;

    // True for head <= tag < tail on the circular active list
    function automatic logic tagInRange(opTag head, opTag tail, opTag tag);
        opTag distTag;
        opTag distTail;
        distTag  = tag - head;
        distTail = tail - head;
        return distTag < distTail;
    endfunction

endpackage

/* memSubsystem.f */
memPipePkg.sv
memExecStage.sv
storeBuffer.sv
memArbiter.sv
dataRam.sv
csrFile.sv
memSubsystem.sv
memSubsystemTb.sv

/* memSubsystem.sv */
/*
 Memory subsystem top
 Connects the execution stage, store buffer, arbiter, data RAM and CSR file
*/
`timescale 1ns/100ps

module memSubsystem import memPipePkg::*; #(
    parameter int ramDepthLog2 = 8,
    parameter int sbDepth      = 4
) (
    input  logic      clk,
    input  logic      arstN,
    input  memOp      opIn,
    input  bypassWord bypassInA,
    input  bypassWord bypassInB,
    input  logic      stall,
    input  logic      clear,
    input  logic      recoveryActive,
    input  opTag      flushHead,
    input  opTag      flushTail,
    output memResult  result
);

    // Four bytes per RAM word
    localparam int unsigned addrLimit = 4 * (2 ** ramDepthLog2);

    logic    sbFull;
    logic    sbConflict;
    logic    sbEmpty;
    logic    loadReq;
    memAddr  loadAddr;
    logic    storeReq;
    memAddr  storeAddr;
    dataWord storeData;
    memAddr  probeAddr;
    logic    csrReq;
    csrNum   csrNumber;
    csrCode  csrOp;
    dataWord csrWriteData;
    dataWord csrReadData;
    logic    drainGrant;
    logic    drainValid;
    memAddr  drainAddr;
    dataWord drainData;
    logic    ramEnable;
    logic    ramWrite;
    memAddr  ramAddr;
    dataWord ramWriteData;
    dataWord ramReadData;

    memExecStage #(
        .addrLimit(addrLimit)
    ) memExecStage_i (
        .clk(clk),
        .arstN(arstN),
        .opIn(opIn),
        .bypassInA(bypassInA),
        .bypassInB(bypassInB),
        .stall(stall),
        .clear(clear),
        .recoveryActive(recoveryActive),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .sbFull(sbFull),
        .sbConflict(sbConflict),
        .sbEmpty(sbEmpty),
        .ramReadData(ramReadData),
        .csrReadData(csrReadData),
        .loadReq(loadReq),
        .loadAddr(loadAddr),
        .storeReq(storeReq),
        .storeAddr(storeAddr),
        .storeData(storeData),
        .probeAddr(probeAddr),
        .csrReq(csrReq),
        .csrNumber(csrNumber),
        .csrOp(csrOp),
        .csrWriteData(csrWriteData),
        .result(result)
    );

    storeBuffer #(
        .depth(sbDepth)
    ) storeBuffer_i (
        .clk(clk),
        .arstN(arstN),
        .storeReq(storeReq),
        .storeAddr(storeAddr),
        .storeData(storeData),
        .probeAddr(probeAddr),
        .drainGrant(drainGrant),
        .full(sbFull),
        .empty(sbEmpty),
        .conflict(sbConflict),
        .drainValid(drainValid),
        .drainAddr(drainAddr),
        .drainData(drainData)
    );

    memArbiter memArbiter_i (
        .loadReq(loadReq),
        .loadAddr(loadAddr),
        .drainValid(drainValid),
        .drainAddr(drainAddr),
        .drainData(drainData),
        .drainGrant(drainGrant),
        .ramEnable(ramEnable),
        .ramWrite(ramWrite),
        .ramAddr(ramAddr),
        .ramWriteData(ramWriteData)
    );

    dataRam #(
        .depthLog2(ramDepthLog2)
    ) dataRam_i (
        .clk(clk),
        .ramEnable(ramEnable),
        .ramWrite(ramWrite),
        .ramAddr(ramAddr),
        .ramWriteData(ramWriteData),
        .ramReadData(ramReadData)
    );

    csrFile csrFile_i (
        .clk(clk),
        .arstN(arstN),
        .csrReq(csrReq),
        .csrNumber(csrNumber),
        .csrOp(csrOp),
        .csrWriteData(csrWriteData),
        .csrReadData(csrReadData)
    );

endmodule

/* memSubsystemTb.sv */
/*
 Testbench for the memory subsystem
 Streams LFSR-generated memory ops through the DUT and checks every result
 against a model of the data memory, the CSRs and the pending stores
*/
`timescale 1ns/100ps

module memSubsystemTb import memPipePkg::*; ();

    // Bytes of data RAM seen by the DUT
    localparam int unsigned ramBytes = 1024;

    // What the execute cycle of one op should produce
    typedef struct packed {
        logic     valid;
        opTag     tag;
        memOpType opType;
        logic     regOk;
        logic     addrBad;
        memAddr   addr;
        dataWord  opB;
        csrNum    csrIdx;
        csrCode   csrOp;
        dataWord  csrValue;
    } expEntry;

    logic      clk;
    logic      arstN;
    memOp      opIn;
    bypassWord bypassInA;
    bypassWord bypassInB;
    logic      stall;
    logic      clear;
    logic      recoveryActive;
    opTag      flushHead;
    opTag      flushTail;
    memResult  result;

    logic [31:0] lfsrState;
    dataWord     modelMem [256];
    logic        written [256];
    dataWord     modelCsr [4];
    logic [7:0]  pendingWords [$];
    memOp        pipeModel;
    expEntry     expected;
    opTag        nextTag;
    logic        fenceDone;
    string       testName;
    int          testChecks;
    int          testErrors;
    int          totalChecks;
    int          totalErrors;

    memSubsystem memSubsystem_i (
        .clk(clk),
        .arstN(arstN),
        .opIn(opIn),
        .bypassInA(bypassInA),
        .bypassInB(bypassInB),
        .stall(stall),
        .clear(clear),
        .recoveryActive(recoveryActive),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .result(result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Run limit, far above the cycles the tests need
    initial begin
        #2000000;
        $display("simulation ran past its cycle limit");
        $display("Test FAILED");
        $finish;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] nextBits(int count);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            bits      = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // Word-aligned base, now and then past the RAM or misaligned
    function automatic dataWord randomBase();
        dataWord base;
        base = nextBits(6) << 2;
        if (nextBits(3) == 0) begin
            base = base + dataWord'(ramBytes);
        end
        if (nextBits(3) == 0) begin
            base = base + nextBits(2);
        end
        return base;
    endfunction

    function automatic memOp randomOp();
        memOp       op;
        logic [2:0] kind;
        logic [2:0] offset;
        logic [1:0] sel;
        op          = '0;
        op.valid    = nextBits(4) != 0;
        kind        = 3'(nextBits(3));
        op.opType   = kind < 3 ? opLoad : kind < 6 ? opStore : kind == 6 ? opCsr : opFence;
        op.tag      = nextTag;
        nextTag     = nextTag + 4'd1;
        op.operandA = randomBase();
        op.operandB = nextBits(32);
        op.readyA   = nextBits(4) != 0;
        op.readyB   = nextBits(4) != 0;
        op.bypassA  = nextBits(2) == 0;
        op.bypassB  = nextBits(2) == 0;
        if (op.opType == opCsr) begin
            op.imm = 12'(nextBits(12));
        end else begin
            offset = 3'(nextBits(3));
            op.imm = {{7{offset[2]}}, offset, 2'b00};
        end
        sel       = 2'(nextBits(2));
        op.csrOp  = sel == 0 ? csrWrite : sel == 1 ? csrSet : csrClear;
        op.csrImm = nextBits(1) != 0;
        return op;
    endfunction

    function automatic dataWord fillWord(int index);
        memAddr a;
        a = memAddr'(index * 4);
        return {a ^ 16'h5a3c, ~a};
    endfunction

    function automatic logic pendingHas(logic [7:0] word);
        foreach (pendingWords[i]) begin
            if (pendingWords[i] == word) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic checkFlag(string what, logic exp, logic act);
        testChecks++;
        if (act !== exp) begin
            testErrors++;
            $display("mismatch %s %s: expected %0b actual %0b", testName, what, exp, act);
        end
    endtask

    task automatic checkData(string what, dataWord exp, dataWord act);
        testChecks++;
        if (act !== exp) begin
            testErrors++;
            $display("mismatch %s %s: expected %h actual %h", testName, what, exp, act);
        end
    endtask

    task automatic checkAddr(string what, memAddr exp, memAddr act);
        testChecks++;
        if (act !== exp) begin
            testErrors++;
            $display("mismatch %s %s: expected %h actual %h", testName, what, exp, act);
        end
    endtask

    task automatic checkTag(string what, opTag exp, opTag act);
        testChecks++;
        if (act !== exp) begin
            testErrors++;
            $display("mismatch %s %s: expected %h actual %h", testName, what, exp, act);
        end
    endtask

    task automatic checkType(string what, memOpType exp, memOpType act);
        testChecks++;
        if (act !== exp) begin
            testErrors++;
            $display("mismatch %s %s: expected %0d actual %0d", testName, what, exp, act);
        end
    endtask

    // Compare the visible result and apply accepted ops to the model
    task automatic checkResult();
        logic       mustReplay;
        logic       mayReplay;
        logic [7:0] word;
        word = expected.addr[9:2];
        checkFlag("valid", expected.valid, result.valid);
        if (expected.valid && result.valid === 1'b1) begin
            mustReplay = !expected.regOk;
            // Buffer state is only bounded by the stores since the last FENCE
            mayReplay = mustReplay ||
                ((expected.opType == opLoad) && !expected.addrBad && pendingHas(word)) ||
                ((expected.opType == opStore) && !expected.addrBad &&
                 (pendingWords.size() >= 4)) ||
                ((expected.opType == opFence) && (pendingWords.size() > 0));
            checkTag("tag", expected.tag, result.tag);
            checkType("type", expected.opType, result.opType);
            checkFlag("fault", expected.regOk && expected.addrBad, result.fault);
            if (mustReplay || !mayReplay) begin
                checkFlag("replay", mustReplay, result.replay);
            end
            if (!result.replay && !result.fault) begin
                case (expected.opType)
                    opLoad: begin
                        checkAddr("load address", expected.addr, result.addr);
                        checkData("load data", modelMem[word], result.data);
                    end
                    opStore: begin
                        checkAddr("store address", expected.addr, result.addr);
                        checkData("store data", expected.opB, result.data);
                        modelMem[word] = expected.opB;
                        written[word]  = 1'b1;
                        pendingWords.push_back(word);
                    end
                    opCsr: begin
                        checkData("csr old value", modelCsr[expected.csrIdx], result.data);
                        case (expected.csrOp)
                            csrWrite: modelCsr[expected.csrIdx] = expected.csrValue;
                            csrSet:   modelCsr[expected.csrIdx] |= expected.csrValue;
                            default:  modelCsr[expected.csrIdx] &= ~expected.csrValue;
                        endcase
                    end
                    default: begin
                        // Completed FENCE means the buffer was empty
                        pendingWords.delete();
                        fenceDone = 1'b1;
                    end
                endcase
            end
        end
    endtask

    task automatic driveCycle(memOp op, logic stallIn, logic clearIn, logic recIn,
                              opTag head, opTag tail, bypassWord bypA, bypassWord bypB);
        dataWord opA;
        logic    validA;
        logic    validB;
        logic    needA;
        logic    isMem;
        dataWord fullAddr;
        @(posedge clk);
        #1;
        checkResult();
        // Expectation for the op now in the pipeline register
        opA      = pipeModel.bypassA ? bypA.data : pipeModel.operandA;
        validA   = pipeModel.bypassA ? bypA.valid : pipeModel.readyA;
        validB   = pipeModel.bypassB ? bypB.valid : pipeModel.readyB;
        needA    = (pipeModel.opType != opFence) &&
                   !((pipeModel.opType == opCsr) && pipeModel.csrImm);
        isMem    = (pipeModel.opType == opLoad) || (pipeModel.opType == opStore);
        fullAddr = opA + {{20{pipeModel.imm[11]}}, pipeModel.imm};
        expected.valid    = pipeModel.valid && !stallIn && !clearIn &&
                            !(recIn && tagInRange(head, tail, pipeModel.tag));
        expected.tag      = pipeModel.tag;
        expected.opType   = pipeModel.opType;
        expected.regOk    = (!needA || validA) && ((pipeModel.opType != opStore) || validB);
        expected.addrBad  = isMem && ((fullAddr >= ramBytes) || (fullAddr[1:0] != 2'b00));
        expected.addr     = fullAddr[15:0];
        expected.opB      = pipeModel.bypassB ? bypB.data : pipeModel.operandB;
        expected.csrIdx   = pipeModel.imm[11:10];
        expected.csrOp    = pipeModel.csrOp;
        expected.csrValue = pipeModel.csrImm ? {22'b0, pipeModel.imm[9:0]} : opA;
        opIn           = op;
        stall          = stallIn;
        clear          = clearIn;
        recoveryActive = recIn;
        flushHead      = head;
        flushTail      = tail;
        bypassInA      = bypA;
        bypassInB      = bypB;
        if (!stallIn) begin
            pipeModel = op;
        end
    endtask

    task automatic driveQuiet(memOp op);
        driveCycle(op, 1'b0, 1'b0, 1'b0, 4'd0, 4'd0, '0, '0);
    endtask

    // Repeat FENCE until one comes back without replay
    task automatic fenceUntilDone();
        memOp fence;
        int   waited;
        fence = '0;
        driveQuiet(fence);
        driveQuiet(fence);
        fence.valid  = 1'b1;
        fence.opType = opFence;
        fenceDone    = 1'b0;
        waited       = 0;
        while (!fenceDone && waited < 40) begin
            fence.tag = nextTag;
            nextTag   = nextTag + 4'd1;
            driveQuiet(fence);
            waited++;
        end
        if (!fenceDone) begin
            testErrors++;
            $display("%s: FENCE still replayed after %0d cycles", testName, waited);
        end
    endtask

    task automatic endTest();
        driveQuiet('0);
        driveQuiet('0);
        $display("test %s: %0d checks, %0d errors", testName, testChecks, testErrors);
        totalChecks += testChecks;
        totalErrors += testErrors;
        testChecks = 0;
        testErrors = 0;
    endtask

    initial begin
        memOp      op;
        logic      held;
        logic      st;
        logic      clr;
        logic      rec;
        opTag      head;
        opTag      tail;
        bypassWord bypA;
        bypassWord bypB;
        lfsrState      = 32'h3f5f;
        arstN          = 1'b0;
        opIn           = '0;
        bypassInA      = '0;
        bypassInB      = '0;
        stall          = 1'b0;
        clear          = 1'b0;
        recoveryActive = 1'b0;
        flushHead      = '0;
        flushTail      = '0;
        pipeModel      = '0;
        expected       = '0;
        nextTag        = '0;
        fenceDone      = 1'b0;
        testChecks     = 0;
        testErrors     = 0;
        totalChecks    = 0;
        totalErrors    = 0;
        for (int i = 0; i < 256; i++) begin
            modelMem[i] = '0;
            written[i]  = 1'b0;
        end
        for (int i = 0; i < 4; i++) begin
            modelCsr[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1 arstN = 1'b1;

        testName = "fill";
        for (int i = 0; i < 256; i++) begin
            op          = '0;
            op.valid    = 1'b1;
            op.opType   = opStore;
            op.tag      = nextTag;
            op.operandA = dataWord'(i * 4);
            op.operandB = fillWord(i);
            op.readyA   = 1'b1;
            op.readyB   = 1'b1;
            nextTag     = nextTag + 4'd1;
            driveQuiet(op);
        end
        fenceUntilDone();
        for (int i = 0; i < 256; i++) begin
            if (!written[i]) begin
                testErrors++;
                $display("%s: word %0d was never written", testName, i);
            end
        end
        endTest();

        // Random ops with stalls, clears, flush ranges and bypass data
        testName = "random";
        held     = 1'b0;
        for (int n = 0; n < 2000; n++) begin
            if (!held) begin
                op = randomOp();
            end
            st        = nextBits(3) == 0;
            clr       = nextBits(4) == 0;
            rec       = nextBits(3) == 0;
            head      = 4'(nextBits(4));
            tail      = 4'(nextBits(4));
            bypA.data  = randomBase();
            bypA.valid = nextBits(3) != 0;
            bypB.data  = nextBits(32);
            bypB.valid = nextBits(3) != 0;
            driveCycle(op, st, clr, rec, head, tail, bypA, bypB);
            held = st;
        end
        endTest();

        testName = "readback";
        fenceUntilDone();
        for (int i = 0; i < 256; i++) begin
            op          = '0;
            op.valid    = 1'b1;
            op.opType   = opLoad;
            op.tag      = nextTag;
            op.operandA = dataWord'(i * 4);
            op.readyA   = 1'b1;
            nextTag     = nextTag + 4'd1;
            driveQuiet(op);
        end
        endTest();

        // Setting no bits reads each CSR back unchanged
        testName = "csr";
        for (int n = 0; n < 4; n++) begin
            op        = '0;
            op.valid  = 1'b1;
            op.opType = opCsr;
            op.tag    = nextTag;
            op.csrOp  = csrSet;
            op.csrImm = 1'b1;
            op.imm    = {2'(n), 10'b0};
            nextTag   = nextTag + 4'd1;
            driveQuiet(op);
        end
        endTest();

        $display("checks %0d, errors %0d", totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator, run it and check the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal -f memSubsystem.f \
    --top-module memSubsystemTb -o memSubsystemSim &&
{ ./obj_dir/memSubsystemSim > sim.log 2>&1 || true; } &&
grep -qx "Test OK" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

/* storeBuffer.sv */
/*
 Store buffer
 Circular FIFO of accepted stores, drained into the data RAM when the
 arbiter grants, with a word-address conflict probe for loads
*/
`timescale 1ns/100ps

module storeBuffer import memPipePkg::*; #(
    parameter int depth = 4
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    storeReq,
    input  memAddr  storeAddr,
    input  dataWord storeData,
    input  memAddr  probeAddr,
    input  logic    drainGrant,
    output logic    full,
    output logic    empty,
    output logic    conflict,
    output logic    drainValid,
    output memAddr  drainAddr,
    output dataWord drainData
);

    localparam int ptrWidth = $clog2(depth);

    typedef logic [ptrWidth-1:0] sbPtr;

    typedef struct packed {
        memAddr  addr;
        dataWord data;
    } sbEntry;

    sbEntry           entries [depth];
    logic [depth-1:0] entryValid;
    sbPtr             headPtr;
    sbPtr             tailPtr;
    logic             push;
    logic             pop;

    function automatic sbPtr nextPtr(sbPtr ptr);
        if (ptr == sbPtr'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full       = entryValid[tailPtr];
    assign empty      = !entryValid[headPtr];
    assign drainValid = entryValid[headPtr];
    assign drainAddr  = entries[headPtr].addr;
    assign drainData  = entries[headPtr].data;

    assign push = storeReq && !full;
    assign pop  = drainGrant && drainValid;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryValid <= '0;
            headPtr    <= '0;
            tailPtr    <= '0;
        end else begin
            if (push) begin
                entryValid[tailPtr] <= 1'b1;
                tailPtr             <= nextPtr(tailPtr);
            end
            if (pop) begin
                entryValid[headPtr] <= 1'b0;
                headPtr             <= nextPtr(headPtr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tailPtr].addr <= storeAddr;
            entries[tailPtr].data <= storeData;
        end
    end

    // Word compare against every pending entry
    always_comb begin
        conflict = 1'b0;
        for (int i = 0; i < depth; i++) begin
            if (entryValid[i] && (entries[i].addr[15:2] == probeAddr[15:2])) begin
                conflict = 1'b1;
            end
        end
    end

endmodule
